/* compile.f */
hw/emu_pkg.sv
hw/tap_cmd_decode.sv
hw/tap_delay_line.sv
hw/tap_combine.sv
hw/local_ctrl_top.sv
tb/local_ctrl_props.sv
tb/tb_local_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_local_ctrl \
	-f compile.f -o sim_local_ctrl > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_local_ctrl > sim.log 2>&1
cat sim.log
# a run that stops early has no pass line either
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
echo "simulation log clean"
exit 0

/* tb/tb_local_ctrl.sv */
module tb_local_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	import emu_pkg::*;

	localparam int ADDR_W = 6;
	localparam int DEPTH = 1 << ADDR_W;

	logic CLK;
	logic rst_n;
	logic cfg_valid;
	logic cfg_kind;
	cfg_word_u cfg_word;
	logic boot_up;
	logic table_commit;
	logic [DELAY_W-1:0] hw_latency;
	logic stream_start;
	logic data_valid;
	logic [DATA_W-1:0] data_re;
	logic [DATA_W-1:0] data_im;
	logic tap_valid;
	logic [N_OBJ-1:0][DATA_W-1:0] tap_re;
	logic [N_OBJ-1:0][DATA_W-1:0] tap_im;
	logic [DATA_W-1:0] echo_re;
	logic [DATA_W-1:0] echo_im;

	// reference tables, active and shadow
	int m_delay [N_OBJ];
	int s_delay [N_OBJ];
	logic [GAIN_W-1:0] m_gain [N_OBJ];
	logic [GAIN_W-1:0] s_gain [N_OBJ];
	int m_lat;
	bit m_boot;
	// samples since stream_start, oldest first
	logic [DATA_W-1:0] hist_re [$];
	logic [DATA_W-1:0] hist_im [$];
	// expected results in order
	logic [N_OBJ-1:0][DATA_W-1:0] exp_tre [$];
	logic [N_OBJ-1:0][DATA_W-1:0] exp_tim [$];
	logic [DATA_W-1:0] exp_ere [$];
	logic [DATA_W-1:0] exp_eim [$];

	logic [31:0] rng;
	string test_name;
	int n_sent;
	int n_checked;

	local_ctrl_top #(
		.ADDR_W(ADDR_W)
	) i_local_ctrl_top (.*);

	bind local_ctrl_top local_ctrl_props #(
		.ADDR_W(ADDR_W)
	) i_local_ctrl_props (
		.CLK(CLK),
		.rst_n(rst_n),
		.data_valid(data_valid),
		.tap_valid(tap_valid),
		.echo_re(echo_re),
		.echo_im(echo_im),
		.tap_offset(tap_offset),
		.tap_ok(tap_ok)
	);

	// 8 ns period
	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	//////////////////////////////////////////////////////////////////////
	// random source and reference math
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// clamp into a signed 16 bit sample
	function automatic logic [DATA_W-1:0] clamp16(input int v);
		if (v > 32767) begin
			return 16'h7fff;
		end else if (v < -32768) begin
			return 16'h8000;
		end
		return DATA_W'(v);
	endfunction

	// Q1.14 gain, floor shift
	function automatic logic [DATA_W-1:0] apply_gain(input logic [DATA_W-1:0] s,
		input logic [GAIN_W-1:0] g);
		int a;
		int b;
		a = int'($signed(s));
		b = int'($signed(g));
		return clamp16((a * b) >>> 14);
	endfunction

	// new sample into history, expected taps and echo out
	task automatic model_sample(input logic [DATA_W-1:0] re, input logic [DATA_W-1:0] im);
		int n;
		int off;
		int sum_re;
		int sum_im;
		logic [N_OBJ-1:0][DATA_W-1:0] t_re;
		logic [N_OBJ-1:0][DATA_W-1:0] t_im;
		hist_re.push_back(re);
		hist_im.push_back(im);
		n = hist_re.size();
		sum_re = 0;
		sum_im = 0;
		for (int k = 0; k < N_OBJ; k++) begin
			off = m_delay[k] - m_lat;
			// sample number n - off, live once it exists
			if (off > 0 && off < DEPTH && n > off) begin
				t_re[k] = apply_gain(hist_re[n - off - 1], m_gain[k]);
				t_im[k] = apply_gain(hist_im[n - off - 1], m_gain[k]);
			end else begin
				t_re[k] = '0;
				t_im[k] = '0;
			end
			sum_re += int'($signed(t_re[k]));
			sum_im += int'($signed(t_im[k]));
		end
		exp_tre.push_back(t_re);
		exp_tim.push_back(t_im);
		exp_ere.push_back(clamp16(sum_re));
		exp_eim.push_back(clamp16(sum_im));
		n_sent++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_taps(input string what, input logic [N_OBJ-1:0][DATA_W-1:0] exp,
		input logic [N_OBJ-1:0][DATA_W-1:0] act);
		if (act !== exp) begin
			$display("** Error: %s %s expected %h actual %h", test_name, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_echo(input logic [DATA_W-1:0] exp_re, input logic [DATA_W-1:0] exp_im,
		input logic [DATA_W-1:0] act_re, input logic [DATA_W-1:0] act_im);
		if (act_re !== exp_re || act_im !== exp_im) begin
			$display("** Error: %s echo expected %h %h actual %h %h", test_name,
				exp_re, exp_im, act_re, act_im);
			stop_run();
		end
	endtask

	// outputs settled by the falling edge
	always @(negedge CLK) begin
		if (rst_n && tap_valid) begin
			if (exp_tre.size() == 0) begin
				$display("** Error: %s: result with no sample in flight", test_name);
				stop_run();
			end else begin
				check_taps("tap_re", exp_tre.pop_front(), tap_re);
				check_taps("tap_im", exp_tim.pop_front(), tap_im);
				check_echo(exp_ere.pop_front(), exp_eim.pop_front(), echo_re, echo_im);
				n_checked++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// one config word, delay view or gain view
	task automatic write_cfg(input bit kind, input int obj, input int val);
		cfg_word_u w;
		w = '0;
		if (kind) begin
			w.gn.obj = OBJ_W'(obj);
			w.gn.gain = GAIN_W'(val);
			if (m_boot) begin
				m_gain[obj] = GAIN_W'(val);
			end else begin
				s_gain[obj] = GAIN_W'(val);
			end
		end else begin
			w.dly.obj = OBJ_W'(obj);
			// reserved bits are don't care
			w.dly.rsvd = 2'(next_rand());
			w.dly.delay = DELAY_W'(val);
			if (m_boot) begin
				m_delay[obj] = val;
			end else begin
				s_delay[obj] = val;
			end
		end
		@(posedge CLK);
		cfg_valid <= 1'b1;
		cfg_kind <= kind;
		cfg_word <= w;
		@(posedge CLK);
		cfg_valid <= 1'b0;
	endtask

	// random ok delay and moderate gain per object
	task automatic load_random(input int lat);
		for (int k = 0; k < N_OBJ; k++) begin
			write_cfg(1'b0, k, lat + 1 + int'(next_rand() % 60));
			write_cfg(1'b1, k, int'(next_rand() % 32768) - 16384);
		end
	endtask

	task automatic set_level(input bit boot, input int lat);
		@(posedge CLK);
		boot_up <= boot;
		hw_latency <= DELAY_W'(lat);
		m_boot = boot;
		m_lat = lat;
	endtask

	task automatic commit_tables();
		@(posedge CLK);
		table_commit <= 1'b1;
		@(posedge CLK);
		table_commit <= 1'b0;
		m_delay = s_delay;
		m_gain = s_gain;
	endtask

	task automatic start_stream();
		@(posedge CLK);
		stream_start <= 1'b1;
		@(posedge CLK);
		stream_start <= 1'b0;
		hist_re.delete();
		hist_im.delete();
	endtask

	// n samples, big ones sit near full scale
	task automatic send_burst(input int n, input bit big, input bit gaps);
		logic [31:0] r;
		logic [DATA_W-1:0] re;
		logic [DATA_W-1:0] im;
		for (int i = 0; i < n; i++) begin
			r = next_rand();
			if (gaps && r[31:30] == 2'b00) begin
				@(posedge CLK);
				data_valid <= 1'b0;
			end
			re = r[15:0];
			im = r[31:16];
			if (big) begin
				re = r[0] ? {8'h80, r[7:0]} : {8'h7f, r[7:0]};
				im = r[1] ? {8'h80, r[15:8]} : {8'h7f, r[15:8]};
			end
			@(posedge CLK);
			data_valid <= 1'b1;
			data_re <= re;
			data_im <= im;
			model_sample(re, im);
		end
		@(posedge CLK);
		data_valid <= 1'b0;
	endtask

	// all results back, then 3 quiet cycles
	task automatic drain();
		int i;
		i = 0;
		while (exp_tre.size() != 0 && i < 50) begin
			@(posedge CLK);
			i++;
		end
		if (exp_tre.size() != 0) begin
			$display("** Error: %s: timeout, results missing for samples sent", test_name);
			stop_run();
		end
		repeat (3) @(posedge CLK);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rng = 32'h117f;
		rst_n = 1'b0;
		cfg_valid = 1'b0;
		cfg_kind = 1'b0;
		cfg_word = '0;
		boot_up = 1'b0;
		table_commit = 1'b0;
		hw_latency = '0;
		stream_start = 1'b0;
		data_valid = 1'b0;
		data_re = '0;
		data_im = '0;
		m_lat = 0;
		m_boot = 1'b0;
		n_sent = 0;
		n_checked = 0;
		test_name = "reset";
		for (int k = 0; k < N_OBJ; k++) begin
			m_delay[k] = 0;
			s_delay[k] = 0;
			m_gain[k] = GAIN_ONE;
			s_gain[k] = GAIN_ONE;
		end
		repeat (4) @(posedge CLK);
		rst_n <= 1'b1;

		test_name = "boot_load";
		set_level(1'b1, 3);
		load_random(3);
		set_level(1'b0, 3);
		start_stream();
		send_burst(80, 1'b0, 1'b1);
		drain();

		// offsets 20..56 from a fresh stream
		test_name = "fill";
		set_level(1'b1, 5);
		for (int k = 0; k < N_OBJ; k++) begin
			write_cfg(1'b0, k, 25 + 12 * k);
		end
		set_level(1'b0, 5);
		start_stream();
		send_burst(70, 1'b0, 1'b0);
		drain();

		// equal to latency, offset 64, offset 63, below latency
		test_name = "invalid";
		set_level(1'b1, 10);
		write_cfg(1'b0, 0, 10);
		write_cfg(1'b0, 1, 74);
		write_cfg(1'b0, 2, 73);
		write_cfg(1'b0, 3, 4);
		set_level(1'b0, 10);
		start_stream();
		send_burst(80, 1'b0, 1'b1);
		drain();
		// objects 0 and 3 come alive, 1 and 2 drop out
		test_name = "latency";
		set_level(1'b0, 2);
		send_burst(40, 1'b0, 1'b1);
		drain();

		test_name = "shadow";
		load_random(2);
		send_burst(40, 1'b0, 1'b1);
		drain();
		test_name = "commit";
		commit_tables();
		send_burst(40, 1'b0, 1'b1);
		drain();

		// offsets 1..4, gains close to +2 and -2
		test_name = "saturation";
		set_level(1'b1, 2);
		for (int k = 0; k < N_OBJ; k++) begin
			write_cfg(1'b0, k, 3 + k);
		end
		write_cfg(1'b1, 0, 32767);
		write_cfg(1'b1, 1, 32000);
		write_cfg(1'b1, 2, -32768);
		write_cfg(1'b1, 3, 31000);
		set_level(1'b0, 2);
		send_burst(60, 1'b1, 1'b0);
		drain();

		test_name = "streaming";
		set_level(1'b1, 2);
		load_random(2);
		set_level(1'b0, 2);
		start_stream();
		send_burst(200, 1'b0, 1'b0);
		drain();

		if (n_checked == n_sent && exp_tre.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("** Error: %0d results for %0d samples sent", n_checked, n_sent);
			stop_run();
		end
	end

endmodule

/* tb/local_ctrl_props.sv */
module local_ctrl_props #(
	parameter int ADDR_W = 6
) (
	input logic CLK,
	input logic rst_n,
	input logic data_valid,
	input logic tap_valid,
	input logic [emu_pkg::DATA_W-1:0] echo_re,
	input logic [emu_pkg::DATA_W-1:0] echo_im,
	input logic [emu_pkg::N_OBJ-1:0][ADDR_W-1:0] tap_offset,
	input logic [emu_pkg::N_OBJ-1:0] tap_ok
);

	timeunit 1ns;
	timeprecision 1ps;

	import emu_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// pipeline latency
	//////////////////////////////////////////////////////////////////////

	// history read stage, then result register
	a_tap_after_data: assert property (@(posedge CLK) disable iff (!rst_n)
		data_valid |-> ##2 tap_valid)
		else $error("tap_valid missing two cycles after data_valid");

	// no result without a sample two cycles back
	a_data_before_tap: assert property (@(posedge CLK) disable iff (!rst_n)
		tap_valid |-> $past(data_valid, 2))
		else $error("tap_valid without data_valid two cycles earlier");

	// sync reset clears the result register
	a_reset_quiet: assert property (@(posedge CLK)
		!rst_n |=> !tap_valid && echo_re == '0 && echo_im == '0)
		else $error("result register not cleared by reset");

	// ok offsets never point at the slot being written
	for (genvar k = 0; k < N_OBJ; k++) begin : g_obj
		a_ok_offset: assert property (@(posedge CLK) disable iff (!rst_n)
			tap_ok[k] |-> tap_offset[k] != '0)
			else $error("ok tap with offset zero");
	end

endmodule

/* hw/local_ctrl_top.sv */
module local_ctrl_top #(
	parameter int ADDR_W = 6
) (
	input logic CLK,
	input logic rst_n,
	// config port
	input logic cfg_valid,
	input logic cfg_kind,
	input emu_pkg::cfg_word_u cfg_word,
	input logic boot_up,
	input logic table_commit,
	input logic [emu_pkg::DELAY_W-1:0] hw_latency,
	// sample stream
	input logic stream_start,
	input logic data_valid,
	input logic [emu_pkg::DATA_W-1:0] data_re,
	input logic [emu_pkg::DATA_W-1:0] data_im,
	// echo out
	output logic tap_valid,
	output logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] tap_re,
	output logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] tap_im,
	output logic [emu_pkg::DATA_W-1:0] echo_re,
	output logic [emu_pkg::DATA_W-1:0] echo_im
);

	import emu_pkg::*;

	// decode to execute
	logic [N_OBJ-1:0][ADDR_W-1:0] tap_offset;
	logic [N_OBJ-1:0] tap_ok;
	// decode to result
	logic [N_OBJ-1:0][GAIN_W-1:0] tap_gain;
	// execute to result
	logic rd_valid;
	logic [N_OBJ-1:0][DATA_W-1:0] rd_re;
	logic [N_OBJ-1:0][DATA_W-1:0] rd_im;

	//////////////////////////////////////////////////////////////////////
	// decode, execute, result
	//////////////////////////////////////////////////////////////////////

	tap_cmd_decode #(
		.ADDR_W(ADDR_W)
	) i_tap_cmd_decode (
		.CLK(CLK),
		.rst_n(rst_n),
		.cfg_valid(cfg_valid),
		.cfg_kind(cfg_kind),
		.boot_up(boot_up),
		.table_commit(table_commit),
		.cfg_word(cfg_word),
		.hw_latency(hw_latency),
		.tap_offset(tap_offset),
		.tap_ok(tap_ok),
		.tap_gain(tap_gain)
	);

	tap_delay_line #(
		.ADDR_W(ADDR_W)
	) i_tap_delay_line (
		.CLK(CLK),
		.rst_n(rst_n),
		.stream_start(stream_start),
		.data_valid(data_valid),
		.data_re(data_re),
		.data_im(data_im),
		.tap_offset(tap_offset),
		.tap_ok(tap_ok),
		.rd_valid(rd_valid),
		.rd_re(rd_re),
		.rd_im(rd_im)
	);

	// two cycles from data_valid to tap_valid
	tap_combine i_tap_combine (
		.CLK(CLK),
		.rst_n(rst_n),
		.rd_valid(rd_valid),
		.rd_re(rd_re),
		.rd_im(rd_im),
		.tap_gain(tap_gain),
		.tap_valid(tap_valid),
		.tap_re(tap_re),
		.tap_im(tap_im),
		.echo_re(echo_re),
		.echo_im(echo_im)
	);

endmodule

/* hw/tap_combine.sv */
module tap_combine (
	input logic CLK,
	input logic rst_n,
	input logic rd_valid,
	input logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] rd_re,
	input logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] rd_im,
	input logic [emu_pkg::N_OBJ-1:0][emu_pkg::GAIN_W-1:0] tap_gain,
	output logic tap_valid,
	output logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] tap_re,
	output logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] tap_im,
	output logic [emu_pkg::DATA_W-1:0] echo_re,
	output logic [emu_pkg::DATA_W-1:0] echo_im
);

	import emu_pkg::*;

	// full product width
	localparam int PROD_W = DATA_W + GAIN_W;
	// sum of N_OBJ saturated taps
	localparam int ACC_W = DATA_W + OBJ_W;

	// clamp a wide signed value into a sample
	function automatic logic [DATA_W-1:0] sat_data(input logic signed [PROD_W-1:0] v);
		logic signed [PROD_W-1:0] hi;
		logic signed [PROD_W-1:0] lo;
		hi = {{(PROD_W-DATA_W+1){1'b0}}, {(DATA_W-1){1'b1}}};
		lo = ~hi;
		if (v > hi) begin
			return hi[DATA_W-1:0];
		end else if (v < lo) begin
			return lo[DATA_W-1:0];
		end
		return v[DATA_W-1:0];
	endfunction

	// sample times Q1.14 gain, back to sample scale
	function automatic logic [DATA_W-1:0] scale(input logic [DATA_W-1:0] s,
		input logic [GAIN_W-1:0] g);
		logic signed [PROD_W-1:0] prod;
		prod = $signed(s) * $signed(g);
		return sat_data(prod >>> GAIN_FRAC);
	endfunction

	logic [N_OBJ-1:0][DATA_W-1:0] scl_re;
	logic [N_OBJ-1:0][DATA_W-1:0] scl_im;
	logic signed [ACC_W-1:0] acc_re;
	logic signed [ACC_W-1:0] acc_im;

	//////////////////////////////////////////////////////////////////////
	// scale and sum
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		acc_re = '0;
		acc_im = '0;
		for (int k = 0; k < N_OBJ; k++) begin
			scl_re[k] = scale(rd_re[k], tap_gain[k]);
			scl_im[k] = scale(rd_im[k], tap_gain[k]);
			// widened, cannot wrap
			acc_re = acc_re + ACC_W'($signed(scl_re[k]));
			acc_im = acc_im + ACC_W'($signed(scl_im[k]));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			tap_valid <= 1'b0;
			tap_re <= '0;
			tap_im <= '0;
			echo_re <= '0;
			echo_im <= '0;
		end else begin
			tap_valid <= rd_valid;
			// hold last result between samples
			if (rd_valid) begin
				tap_re <= scl_re;
				tap_im <= scl_im;
				echo_re <= sat_data(PROD_W'(acc_re));
				echo_im <= sat_data(PROD_W'(acc_im));
			end
		end
	end

endmodule

/* hw/tap_delay_line.sv */
module tap_delay_line #(
	parameter int ADDR_W = 6
) (
	input logic CLK,
	input logic rst_n,
	input logic stream_start,
	input logic data_valid,
	input logic [emu_pkg::DATA_W-1:0] data_re,
	input logic [emu_pkg::DATA_W-1:0] data_im,
	input logic [emu_pkg::N_OBJ-1:0][ADDR_W-1:0] tap_offset,
	input logic [emu_pkg::N_OBJ-1:0] tap_ok,
	output logic rd_valid,
	output logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] rd_re,
	output logic [emu_pkg::N_OBJ-1:0][emu_pkg::DATA_W-1:0] rd_im
);

	import emu_pkg::*;

	// fill count saturates here
	localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

	//////////////////////////////////////////////////////////////////////
	// storage and pointers
	//////////////////////////////////////////////////////////////////////

	// sample history, circular
	logic [DATA_W-1:0] hist_re [2**ADDR_W];
	logic [DATA_W-1:0] hist_im [2**ADDR_W];

	// next write slot
	logic [ADDR_W-1:0] wr_ptr;
	// samples written since stream_start
	logic [ADDR_W:0] fill_cnt;

	// pointer and count as seen by this cycle's sample
	logic [ADDR_W-1:0] cur_ptr;
	logic [ADDR_W:0] cur_fill;
	logic [ADDR_W:0] next_fill;

	// per object read address and live flag
	logic [ADDR_W-1:0] rd_addr [N_OBJ];
	logic [N_OBJ-1:0] live;

	//////////////////////////////////////////////////////////////////////
	// tap select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// start in the same cycle makes this sample number 1
		if (stream_start) begin
			cur_ptr = '0;
			cur_fill = '0;
		end else begin
			cur_ptr = wr_ptr;
			cur_fill = fill_cnt;
		end
		// saturate at depth
		if (cur_fill == DEPTH) begin
			next_fill = DEPTH;
		end else begin
			next_fill = cur_fill + 1'b1;
		end
		for (int k = 0; k < N_OBJ; k++) begin
			// offset back from the slot being written
			rd_addr[k] = cur_ptr - tap_offset[k];
			// not yet written since start, or bad entry
			live[k] = tap_ok[k] && ({1'b0, tap_offset[k]} <= cur_fill);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// control state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			fill_cnt <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= data_valid;
			if (data_valid) begin
				wr_ptr <= cur_ptr + 1'b1;
				fill_cnt <= next_fill;
			end else if (stream_start) begin
				wr_ptr <= '0;
				fill_cnt <= '0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// history write and tap read
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (data_valid) begin
			hist_re[cur_ptr] <= data_re;
			hist_im[cur_ptr] <= data_im;
			// read sees the old contents, offset is never 0 when live
			for (int k = 0; k < N_OBJ; k++) begin
				if (live[k]) begin
					rd_re[k] <= hist_re[rd_addr[k]];
					rd_im[k] <= hist_im[rd_addr[k]];
				end else begin
					rd_re[k] <= '0;
					rd_im[k] <= '0;
				end
			end
		end
	end

endmodule

/* hw/tap_cmd_decode.sv */
module tap_cmd_decode #(
	parameter int ADDR_W = 6
) (
	input logic CLK,
	input logic rst_n,
	input logic cfg_valid,
	input logic cfg_kind,
	input logic boot_up,
	input logic table_commit,
	input emu_pkg::cfg_word_u cfg_word,
	input logic [emu_pkg::DELAY_W-1:0] hw_latency,
	output logic [emu_pkg::N_OBJ-1:0][ADDR_W-1:0] tap_offset,
	output logic [emu_pkg::N_OBJ-1:0] tap_ok,
	output logic [emu_pkg::N_OBJ-1:0][emu_pkg::GAIN_W-1:0] tap_gain
);

	import emu_pkg::*;

	// history depth, offsets must stay below this
	localparam int DEPTH = 1 << ADDR_W;

	// active table drives the datapath
	logic [DELAY_W-1:0] act_delay [N_OBJ];
	logic [GAIN_W-1:0] act_gain [N_OBJ];

	// shadow table, staged for the next scenario
	logic [DELAY_W-1:0] shd_delay [N_OBJ];
	logic [GAIN_W-1:0] shd_gain [N_OBJ];

	// decoded config fields
	logic [OBJ_W-1:0] wr_obj;
	logic [DELAY_W-1:0] wr_delay;
	logic [GAIN_W-1:0] wr_gain;
	logic wr_dly_en;
	logic wr_gain_en;

	// delay minus hw latency, per object
	logic [DELAY_W-1:0] diff [N_OBJ];

	//////////////////////////////////////////////////////////////////////
	// config word decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// object index sits in the same bits in both views
		wr_obj = cfg_word.dly.obj;
		wr_delay = cfg_word.dly.delay;
		wr_gain = cfg_word.gn.gain;
		// kind 0 delay, kind 1 gain
		wr_dly_en = cfg_valid && !cfg_kind;
		wr_gain_en = cfg_valid && cfg_kind;
	end

	//////////////////////////////////////////////////////////////////////
	// table update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			// delay 0 never passes the ok check
			for (int k = 0; k < N_OBJ; k++) begin
				act_delay[k] <= '0;
				act_gain[k] <= GAIN_ONE;
				shd_delay[k] <= '0;
				shd_gain[k] <= GAIN_ONE;
			end
		end else begin
			// scenario change, whole shadow at once
			if (table_commit) begin
				for (int k = 0; k < N_OBJ; k++) begin
					act_delay[k] <= shd_delay[k];
					act_gain[k] <= shd_gain[k];
				end
			end
			// boot writes straight to active
			if (wr_dly_en) begin
				if (boot_up) begin
					act_delay[wr_obj] <= wr_delay;
				end else begin
					shd_delay[wr_obj] <= wr_delay;
				end
			end
			if (wr_gain_en) begin
				if (boot_up) begin
					act_gain[wr_obj] <= wr_gain;
				end else begin
					shd_gain[wr_obj] <= wr_gain;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// offsets from current latency
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < N_OBJ; k++) begin
			diff[k] = act_delay[k] - hw_latency;
			// must be positive and fit in the history
			tap_ok[k] = (act_delay[k] > hw_latency) && (int'(diff[k]) < DEPTH);
			tap_offset[k] = ADDR_W'(diff[k]);
			tap_gain[k] = act_gain[k];
		end
	end

endmodule

/* hw/emu_pkg.sv */
package emu_pkg;

	//////////////////////////////////////////////////////////////////////
	// datapath widths
	//////////////////////////////////////////////////////////////////////

	// one sample component, real or imaginary
	localparam int DATA_W = 16;

	// reflecting objects per channel
	localparam int N_OBJ = 4;
	localparam int OBJ_W = 2;

	// delay and hw latency, in samples
	localparam int DELAY_W = 14;

	// gain is signed Q1.14
	localparam int GAIN_W = 16;
	localparam int GAIN_FRAC = 14;
	localparam logic [GAIN_W-1:0] GAIN_ONE = 16'd16384;

	//////////////////////////////////////////////////////////////////////
	// configuration word
	//////////////////////////////////////////////////////////////////////

	localparam int CFG_W = 18;

	// same word, two meanings, picked by cfg_kind
	typedef union packed {
		// cfg_kind 0
		struct packed {
			logic [OBJ_W-1:0] obj;
			logic [CFG_W-OBJ_W-DELAY_W-1:0] rsvd;
			logic [DELAY_W-1:0] delay;
		} dly;
		// cfg_kind 1
		struct packed {
			logic [OBJ_W-1:0] obj;
			logic [GAIN_W-1:0] gain;
		} gn;
	} cfg_word_u;

endpackage
